/* files.f */
+incdir+verif
verilog/core_pkg.sv
verilog/reset_sequencer.sv
verilog/control_fsm.sv
verilog/alu.sv
verilog/register_file.sv
verilog/datapath.sv
verilog/mc_core.sv
verif/core_props.sv
verif/tb_mc_core.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_mc_core -f files.f && ./obj_dir/Vtb_mc_core || exit 1

/* verif/core_props.sv */
`timescale 1ns/100ps
`default_nettype none

module core_props (
    input wire logic             clk_i,
    input wire logic             resetComplete,
    input wire logic             mem_busy_i,
    input core_pkg::main_state_t state_i,
    input core_pkg::main_state_t next_state_i,
    input core_pkg::ctrl_t       ctrl_i
);

    import core_pkg::*;

    // Any strobe that changes state
    logic any_load;

    assign any_load = ctrl_i.pc_ld | ctrl_i.pcp_ld | ctrl_i.ir_ld | ctrl_i.alu_ld
                    | ctrl_i.flags_ld | ctrl_i.rg_wr | ctrl_i.mem_rd;

    // IR capture needs ready memory and a read strobe one cycle earlier
    assert property (@(posedge clk_i) disable iff (resetComplete)
        ctrl_i.ir_ld |-> !mem_busy_i && $past(ctrl_i.mem_rd))
        else $error("ir_ld while memory busy or without a prior read");

    // Quiet bundle in reset
    assert property (@(posedge clk_i) resetComplete |-> !any_load)
        else $error("control strobe active during reset");

    // Read strobe on every entry to Fetch
    assert property (@(posedge clk_i) disable iff (resetComplete)
        (state_i != Fetch && next_state_i == Fetch) |-> ctrl_i.mem_rd)
        else $error("Fetch entered without mem_rd");

endmodule

`default_nettype wire

/* verif/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ------------------------------
// Random source
// ------------------------------
// LCG state shared by program build and busy pattern
logic [31:0] lcg_state = 32'd73541;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// Value in 0 .. n-1 from the stronger upper LCG bits
function automatic logic [31:0] rand_range(input logic [31:0] n);
    logic [31:0] r;
    r = lcg_next();
    return (r >> 8) % n;
endfunction

// ------------------------------
// Instruction encoders
// ------------------------------
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_RTYPE};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm12, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
    return {imm12, rs1, f3, rd, OPC_ITYPE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BTYPE};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JTYPE};
endfunction

// ------------------------------
// Program builder
// ------------------------------
function automatic void build_program();
    int          i;
    int          k;
    int          last;
    logic [31:0] sel;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [6:0]  f7;
    logic [11:0] imm12;
    // Fill word has a zero opcode field and parks a stray fetch in Illegal
    for (i = 0; i < MEM_WORDS; i++) begin
        mem[i] = {i[24:0], 7'h00};
    end
    // Start address at the vector word
    mem[0] = PROG_BASE * 4;
    last = PROG_BASE + PROG_LEN - 1;
    // Prologue seeds x1..x7
    for (i = 1; i < 8; i++) begin
        mem[PROG_BASE + i - 1] = enc_i(12'(rand_range(4096)), 5'd0, 3'd0, 5'(i));
    end
    for (i = PROG_BASE + 7; i < last; i++) begin
        sel = rand_range(10);
        rd  = 5'(rand_range(8));
        rs1 = 5'(rand_range(8));
        rs2 = 5'(rand_range(8));
        if (sel < 4) begin
            f3 = 3'(rand_range(8));
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_range(2) == 32'd1) ? 7'h20 : 7'h00;
            mem[i] = enc_r(f7, rs2, rs1, f3, rd);
        end else if (sel < 7) begin
            f3 = 3'(rand_range(8));
            if (f3 == 3'd1) begin
                imm12 = {7'h00, 5'(rand_range(32))};
            end else if (f3 == 3'd5) begin
                f7    = (rand_range(2) == 32'd1) ? 7'h20 : 7'h00;
                imm12 = {f7, 5'(rand_range(32))};
            end else begin
                imm12 = 12'(rand_range(4096));
            end
            mem[i] = enc_i(imm12, rs1, f3, rd);
        end else begin
            // Forward by 1 to 3 words but never past the final loop
            k = int'(rand_range(3)) + 1;
            if (i + k > last) begin
                k = last - i;
            end
            if (sel < 9) begin
                // beq and bne for sel 7 and the four compares for sel 8
                f3 = (sel == 32'd7) ? 3'(rand_range(2)) : 3'(rand_range(4)) + 3'd4;
                mem[i] = enc_b(13'(k * 4), rs2, rs1, f3);
            end else begin
                mem[i] = enc_j(21'(k * 4), rd);
            end
        end
    end
    // Self-loop ends the program
    mem[last] = enc_j(21'd0, 5'd0);
endfunction

// ------------------------------
// Architectural reference
// ------------------------------
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [31:0] fill;
    // Sign bits shifted in by sra
    fill = a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0;
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? (a >> b[4:0]) | fill : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

// Runs the program and queues every write to x1..x31
function automatic void run_reference();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] ins;
    logic [31:0] res;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic        wr;
    int          r;
    int          steps;
    for (r = 0; r < 32; r++) begin
        regs[r] = '0;
    end
    pc    = mem[0];
    steps = 0;
    while (mem[pc[11:2]] != enc_j(21'd0, 5'd0) && steps < 2000) begin
        ins     = mem[pc[11:2]];
        f3      = ins[14:12];
        rd      = ins[11:7];
        wr      = 1'b0;
        res     = '0;
        next_pc = pc + 32'd4;
        case (ins[6:0])
            OPC_RTYPE: begin
                res = alu_ref(f3, ins[30], regs[ins[19:15]], regs[ins[24:20]]);
                wr  = 1'b1;
            end
            OPC_ITYPE: begin
                res = alu_ref(f3, (f3 == 3'd5) && ins[30], regs[ins[19:15]],
                              {{20{ins[31]}}, ins[31:20]});
                wr  = 1'b1;
            end
            OPC_BTYPE: begin
                if (branch_ref(f3, regs[ins[19:15]], regs[ins[24:20]])) begin
                    next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                    ins[11:8], 1'b0};
                end
            end
            default: begin
                // jal is the only other kind generated
                res     = pc + 32'd4;
                wr      = 1'b1;
                next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                ins[30:21], 1'b0};
            end
        endcase
        if (wr && rd != 5'd0) begin
            regs[rd] = res;
            exp_addr.push_back(rd);
            exp_data.push_back(res);
        end
        pc = next_pc;
        steps++;
    end
    loop_addr = pc;
endfunction

`endif

/* verif/tb_mc_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mc_core;

    import core_pkg::*;

    localparam int MEM_WORDS   = 1024;
    localparam int PROG_BASE   = 64;
    localparam int PROG_LEN    = 48;
    localparam int STAY_CYCLES = 40;
    localparam int RUN_LIMIT   = 20000;

    logic            clk_i;
    logic            resetComplete;
    logic            mem_busy_i;
    logic [XLEN-1:0] mem_data_i;
    logic [XLEN-1:0] mem_addr_o;
    logic            mem_rd_o;
    wb_t             wb_o;
    logic            busy_en;

    // Instruction memory and expected write list
    logic [31:0] mem [MEM_WORDS];
    logic [4:0]  exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] loop_addr;

    `include "tb_ref_model.svh"

    mc_core DUT (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .mem_busy_i    (mem_busy_i),
        .mem_data_i    (mem_data_i),
        .mem_addr_o    (mem_addr_o),
        .mem_rd_o      (mem_rd_o),
        .wb_o          (wb_o)
    );

    bind control_fsm core_props u_props (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .mem_busy_i    (mem_busy_i),
        .state_i       (state_q),
        .next_state_i  (state_d),
        .ctrl_i        (ctrl_o)
    );

    // Asynchronous word-addressed read
    assign mem_data_i = mem[mem_addr_o[11:2]];

    // 8 ns clock
    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------
    // Reporting
    // ------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping on first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t ns: %s is %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    // ------------------------------
    // Waits
    // ------------------------------
    // PC leaves 0 once the vector word is loaded
    task automatic wait_leave_vector();
        int cycles;
        cycles = 0;
        while (mem_addr_o == RESET_VECTOR) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > 20) begin
                report_failure("Timeout: core never left the reset vector");
            end
        end
    endtask

    // Loop word and loop+4 alternate while the core spins
    task automatic wait_self_loop();
        int cycles;
        int stay;
        cycles = 0;
        stay   = 0;
        while (stay < STAY_CYCLES) begin
            @(negedge clk_i);
            cycles++;
            if (mem_addr_o == loop_addr || mem_addr_o == loop_addr + 32'd4) begin
                stay++;
            end else begin
                stay = 0;
            end
            if (cycles > RUN_LIMIT) begin
                report_failure("Timeout: program never reached its final self-loop");
            end
        end
    endtask

    // Random fetch stalls in about one cycle of three
    always @(negedge clk_i) begin
        if (busy_en) begin
            mem_busy_i <= (rand_range(3) == 32'd0);
        end
    end

    // ------------------------------
    // Writeback compare
    // ------------------------------
    // Sampled mid-cycle to see one write per high cycle of we
    always @(negedge clk_i) begin
        if (!resetComplete && wb_o.we) begin
            if (exp_addr.size() == 0) begin
                report_failure("Register write seen after all expected writes");
            end else begin
                check_value("writeback register", 32'(wb_o.addr), 32'(exp_addr[0]));
                check_value("writeback data", wb_o.data, exp_data[0]);
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    // Main flow
    initial begin
        resetComplete = 1'b1;
        mem_busy_i    = 1'b0;
        busy_en       = 1'b0;
        build_program();
        run_reference();
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        // Read strobe stays low while reset is held
        check_value("mem_rd_o in reset", 32'(mem_rd_o), 32'd0);
        resetComplete <= 1'b0;
        // First fetch address comes from the vector word
        wait_leave_vector();
        check_value("first fetch address", mem_addr_o, mem[0]);
        // Step 3 reads the first instruction word
        check_value("mem_rd_o at last vector step", 32'(mem_rd_o), 32'd1);
        busy_en <= 1'b1;
        wait_self_loop();
        if (exp_addr.size() != 0) begin
            report_failure($sformatf("Run ended with %0d expected register writes missing",
                                     exp_addr.size()));
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire logic [core_pkg::XLEN-1:0] a_i,
    input  wire logic [core_pkg::XLEN-1:0] b_i,
    input  core_pkg::alu_op_t              op_i,
    output logic      [core_pkg::XLEN-1:0] y_o,
    output core_pkg::flags_t               flags_o
);

    import core_pkg::*;

    // a - b with the borrow in the top bit
    logic [XLEN:0]   diff;
    logic [4:0]      shamt;

    assign diff  = {1'b0, a_i} - {1'b0, b_i};
    assign shamt = b_i[4:0];

    // ------------------------------
    // Result
    // ------------------------------
    always_comb begin
        case (op_i)
            ADD:     y_o = a_i + b_i;
            SUB:     y_o = diff[XLEN-1:0];
            SLL:     y_o = a_i << shamt;
            SLT:     y_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            SLTU:    y_o = {{(XLEN-1){1'b0}}, a_i < b_i};
            XOR:     y_o = a_i ^ b_i;
            SRL:     y_o = a_i >> shamt;
            SRA:     y_o = $unsigned($signed(a_i) >>> shamt);
            OR:      y_o = a_i | b_i;
            AND:     y_o = a_i & b_i;
            default: y_o = a_i + b_i;
        endcase
    end

    // ------------------------------
    // Flags, always from the subtraction
    // ------------------------------
    // Borrow, so c means a below b unsigned
    assign flags_o.c = diff[XLEN];
    assign flags_o.n = diff[XLEN-1];
    assign flags_o.z = (diff[XLEN-1:0] == '0);
    // Signed overflow when operand signs differ and result sign flips
    assign flags_o.v = (a_i[XLEN-1] ^ b_i[XLEN-1]) & (a_i[XLEN-1] ^ diff[XLEN-1]);

endmodule

`default_nettype wire

/* verilog/control_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module control_fsm (
    input  wire logic                      clk_i,
    input  wire logic                      resetComplete,
    input  wire logic [1:0]                seq_step_i,
    input  wire logic                      seq_done_i,
    input  wire logic                      mem_busy_i,
    input  wire logic [core_pkg::XLEN-1:0] ir_i,
    input  core_pkg::flags_t               flags_i,
    output core_pkg::ctrl_t                ctrl_o
);

    import core_pkg::*;

    // IR fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [2:0] funct7up;
    logic       rd_zero;
    logic       take_branch;

    main_state_t state_q, state_d;
    exec_state_t exec_q, exec_d;

    assign opcode   = ir_i[6:0];
    assign funct3   = ir_i[14:12];
    assign funct7up = ir_i[31:29];
    assign rd_zero  = (ir_i[11:7] == '0);

    // Branch decision from the stored flags
    always_comb begin
        case (funct3)
            3'b000:  take_branch = flags_i.z;
            3'b001:  take_branch = ~flags_i.z;
            3'b100:  take_branch = flags_i.n ^ flags_i.v;
            3'b101:  take_branch = (flags_i.n == flags_i.v);
            3'b110:  take_branch = flags_i.c;
            3'b111:  take_branch = ~flags_i.c;
            default: take_branch = 1'b0;
        endcase
    end

    // ------------------------------
    // Control decode
    // ------------------------------
    always_comb begin
        // Idle bundle, PC + 4 on the ALU
        ctrl_o  = '0;
        state_d = state_q;
        exec_d  = exec_q;
        case (state_q)
            Reset: begin
                // Vector sequence runs only after release
                if (!resetComplete) begin
                    case (seq_step_i)
                        2'd0: begin
                            ctrl_o.pc_ld  = 1'b1;
                            ctrl_o.pc_src = reset_vec;
                        end
                        2'd2: begin
                            ctrl_o.pc_ld  = 1'b1;
                            ctrl_o.pc_src = reset_adr;
                        end
                        default: ctrl_o.mem_rd = 1'b1;
                    endcase
                end
                if (seq_done_i) begin
                    state_d = Fetch;
                end
            end
            Fetch: begin
                if (mem_busy_i) begin
                    // Keep reading until memory is ready
                    ctrl_o.mem_rd = 1'b1;
                end else begin
                    ctrl_o.ir_ld  = 1'b1;
                    ctrl_o.pcp_ld = 1'b1;
                    state_d       = Decode;
                end
            end
            Decode: begin
                // PC + 4 from the default ALU setup
                ctrl_o.pc_ld = 1'b1;
                state_d      = Execute;
                case (opcode)
                    OPC_RTYPE: exec_d = RType;
                    OPC_ITYPE: exec_d = ITALU;
                    OPC_BTYPE: exec_d = BType;
                    OPC_JTYPE: exec_d = JTJal;
                    default:   exec_d = Illegal;
                endcase
            end
            Execute: begin
                case (exec_q)
                    RType, ITALU: begin
                        ctrl_o.alu_ld = 1'b1;
                        ctrl_o.a_src  = rsa;
                        if (exec_q == RType) begin
                            ctrl_o.b_src  = rsb;
                            ctrl_o.alu_op = alu_op_t'({funct3, funct7up});
                        end else begin
                            ctrl_o.b_src = imm;
                            // Only shifts keep the upper immediate bits
                            if (funct3 == 3'b001 || funct3 == 3'b101) begin
                                ctrl_o.alu_op = alu_op_t'({funct3, funct7up});
                            end else begin
                                ctrl_o.alu_op = alu_op_t'({funct3, 3'b000});
                            end
                        end
                        // No writeback cycle for x0
                        if (rd_zero) begin
                            ctrl_o.mem_rd = 1'b1;
                            state_d       = Fetch;
                        end else begin
                            exec_d = (exec_q == RType) ? RTCmpl : ITALUCmpl;
                        end
                    end
                    RTCmpl, ITALUCmpl: begin
                        // Result waits in ALU-out
                        ctrl_o.wd_src = alu_out;
                        ctrl_o.rg_wr  = 1'b1;
                        ctrl_o.mem_rd = 1'b1;
                        state_d       = Fetch;
                    end
                    BType: begin
                        // Compare rs1 with rs2 and keep the flags
                        ctrl_o.a_src    = rsa;
                        ctrl_o.b_src    = rsb;
                        ctrl_o.alu_op   = SUB;
                        ctrl_o.flags_ld = 1'b1;
                        exec_d          = BTBranch;
                    end
                    BTBranch: begin
                        // Target is PC prior + imm
                        ctrl_o.a_src = prior;
                        ctrl_o.b_src = imm;
                        if (take_branch) begin
                            ctrl_o.pc_ld = 1'b1;
                            exec_d       = PreFetch;
                        end else begin
                            ctrl_o.mem_rd = 1'b1;
                            state_d       = Fetch;
                        end
                    end
                    JTJal: begin
                        ctrl_o.a_src = prior;
                        ctrl_o.b_src = imm;
                        ctrl_o.pc_ld = 1'b1;
                        exec_d       = rd_zero ? PreFetch : JTJalRtr;
                    end
                    JTJalRtr: begin
                        // Return address PC prior + 4
                        ctrl_o.a_src  = prior;
                        ctrl_o.wd_src = alu_direct;
                        ctrl_o.rg_wr  = 1'b1;
                        exec_d        = PreFetch;
                    end
                    PreFetch: begin
                        ctrl_o.mem_rd = 1'b1;
                        state_d       = Fetch;
                    end
                    default: begin
                        // Illegal opcode, park here
                        exec_d = Illegal;
                    end
                endcase
            end
            default: state_d = Reset;
        endcase
    end

    // ------------------------------
    // State registers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            state_q <= Reset;
            exec_q  <= PreFetch;
        end else begin
            state_q <= state_d;
            exec_q  <= exec_d;
        end
    end

endmodule

`default_nettype wire

/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    // ------------------------------
    // Widths and fixed addresses
    // ------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Word holding the start address
    localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0000;

    // RV32I opcodes still decoded
    localparam logic [6:0] OPC_RTYPE = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE = 7'b0010011;
    localparam logic [6:0] OPC_BTYPE = 7'b1100011;
    localparam logic [6:0] OPC_JTYPE = 7'b1101111;

    // ALU code is {funct3, funct7[31:29]}
    typedef enum logic [5:0] {
        ADD  = 6'b000_000,
        SUB  = 6'b000_010,
        SLL  = 6'b001_000,
        SLT  = 6'b010_000,
        SLTU = 6'b011_000,
        XOR  = 6'b100_000,
        SRL  = 6'b101_000,
        SRA  = 6'b101_010,
        OR   = 6'b110_000,
        AND  = 6'b111_000
    } alu_op_t;

    // Flags of rs1 - rs2, c is the borrow
    typedef struct packed {
        logic v;
        logic n;
        logic c;
        logic z;
    } flags_t;

    typedef enum logic [1:0] {Reset, Fetch, Decode, Execute} main_state_t;

    typedef enum logic [3:0] {
        RType, RTCmpl, ITALU, ITALUCmpl, BType, BTBranch,
        JTJal, JTJalRtr, PreFetch, Illegal
    } exec_state_t;

    // ------------------------------
    // Mux selects, zero is the idle choice
    // ------------------------------
    typedef enum logic [1:0] {alu_imm, reset_vec, reset_adr} pc_src_t;
    typedef enum logic [1:0] {pc, rsa, prior} a_src_t;
    typedef enum logic [1:0] {four, rsb, imm} b_src_t;
    typedef enum logic {alu_out, alu_direct} wd_src_t;

    // Control bundle from the FSM to the datapath
    typedef struct packed {
        logic    pc_ld;
        logic    pcp_ld;
        logic    ir_ld;
        logic    alu_ld;
        logic    flags_ld;
        logic    rg_wr;
        pc_src_t pc_src;
        a_src_t  a_src;
        b_src_t  b_src;
        wd_src_t wd_src;
        alu_op_t alu_op;
        logic    mem_rd;
    } ctrl_t;

    // Register write port, also the writeback trace
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

/* verilog/datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module datapath (
    input  wire logic                      clk_i,
    input  wire logic                      resetComplete,
    input  core_pkg::ctrl_t                ctrl_i,
    input  wire logic [core_pkg::XLEN-1:0] mem_data_i,
    output logic      [core_pkg::XLEN-1:0] mem_addr_o,
    output logic      [core_pkg::XLEN-1:0] ir_o,
    output core_pkg::flags_t               flags_o,
    output core_pkg::wb_t                  wb_o
);

    import core_pkg::*;

    // Architectural and staging registers
    logic [XLEN-1:0] pc_q, pcp_q, ir_q, alu_out_q;
    flags_t          flags_q;

    logic [XLEN-1:0] a_mux, b_mux, imm_val, alu_y;
    logic [XLEN-1:0] rd1, rd2;
    flags_t          alu_flags;
    wb_t             wb;

    // ------------------------------
    // Immediate generator
    // ------------------------------
    always_comb begin
        case (ir_q[6:0])
            OPC_BTYPE: imm_val = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25],
                                  ir_q[11:8], 1'b0};
            OPC_JTYPE: imm_val = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20],
                                  ir_q[30:21], 1'b0};
            // I-type and don't-care cases
            default:   imm_val = {{20{ir_q[31]}}, ir_q[31:20]};
        endcase
    end

    // Operand muxes
    always_comb begin
        case (ctrl_i.a_src)
            rsa:     a_mux = rd1;
            prior:   a_mux = pcp_q;
            default: a_mux = pc_q;
        endcase
        case (ctrl_i.b_src)
            rsb:     b_mux = rd2;
            imm:     b_mux = imm_val;
            default: b_mux = 32'd4;
        endcase
    end

    alu u_alu (
        .a_i     (a_mux),
        .b_i     (b_mux),
        .op_i    (ctrl_i.alu_op),
        .y_o     (alu_y),
        .flags_o (alu_flags)
    );

    // Write data, held result or direct ALU output
    assign wb.we   = ctrl_i.rg_wr;
    assign wb.addr = ir_q[11:7];
    assign wb.data = (ctrl_i.wd_src == alu_out) ? alu_out_q : alu_y;

    register_file u_regs (
        .clk_i (clk_i),
        .ra1_i (ir_q[19:15]),
        .ra2_i (ir_q[24:20]),
        .rd1_o (rd1),
        .rd2_o (rd2),
        .wb_i  (wb)
    );

    // ------------------------------
    // Registers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            pc_q <= RESET_VECTOR;
            ir_q <= '0;
        end else begin
            if (ctrl_i.pc_ld) begin
                case (ctrl_i.pc_src)
                    reset_vec: pc_q <= RESET_VECTOR;
                    reset_adr: pc_q <= mem_data_i;
                    default:   pc_q <= alu_y;
                endcase
            end
            if (ctrl_i.ir_ld) begin
                ir_q <= mem_data_i;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (ctrl_i.pcp_ld) pcp_q <= pc_q;
        if (ctrl_i.alu_ld) alu_out_q <= alu_y;
        if (ctrl_i.flags_ld) flags_q <= alu_flags;
    end

    assign mem_addr_o = pc_q;
    assign ir_o       = ir_q;
    assign flags_o    = flags_q;
    assign wb_o       = wb;

endmodule

`default_nettype wire

/* verilog/mc_core.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_core (
    input  wire logic                      clk_i,
    input  wire logic                      resetComplete,
    input  wire logic                      mem_busy_i,
    input  wire logic [core_pkg::XLEN-1:0] mem_data_i,
    output logic      [core_pkg::XLEN-1:0] mem_addr_o,
    output logic                           mem_rd_o,
    output core_pkg::wb_t                  wb_o
);

    import core_pkg::*;

    logic [1:0]      seq_step;
    logic            seq_done;
    ctrl_t           ctrl;
    logic [XLEN-1:0] ir;
    flags_t          flags;

    // Reset-vector step counter
    reset_sequencer u_seq (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .seq_step_o    (seq_step),
        .seq_done_o    (seq_done)
    );

    control_fsm u_fsm (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .seq_step_i    (seq_step),
        .seq_done_i    (seq_done),
        .mem_busy_i    (mem_busy_i),
        .ir_i          (ir),
        .flags_i       (flags),
        .ctrl_o        (ctrl)
    );

    datapath u_dp (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .ctrl_i        (ctrl),
        .mem_data_i    (mem_data_i),
        .mem_addr_o    (mem_addr_o),
        .ir_o          (ir),
        .flags_o       (flags),
        .wb_o          (wb_o)
    );

    // Read strobe straight from the control bundle
    assign mem_rd_o = ctrl.mem_rd;

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  wire logic                            clk_i,
    input  wire logic [core_pkg::REG_ADDR_W-1:0] ra1_i,
    input  wire logic [core_pkg::REG_ADDR_W-1:0] ra2_i,
    output logic      [core_pkg::XLEN-1:0]       rd1_o,
    output logic      [core_pkg::XLEN-1:0]       rd2_o,
    input  core_pkg::wb_t                        wb_i
);

    import core_pkg::*;

    // x1 to x31, x0 has no storage
    logic [XLEN-1:0] regs [1:(2**REG_ADDR_W)-1];

    // Write port, x0 writes dropped
    always_ff @(posedge clk_i) begin
        if (wb_i.we && (wb_i.addr != '0)) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // Asynchronous reads, x0 reads zero
    assign rd1_o = (ra1_i == '0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : regs[ra2_i];

endmodule

`default_nettype wire

/* verilog/reset_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module reset_sequencer (
    input  wire logic       clk_i,
    input  wire logic       resetComplete,
    output logic      [1:0] seq_step_o,
    output logic            seq_done_o
);

    // Current step of the vector sequence
    logic [1:0] step_q;

    // Restart on reset, then saturate at step 3
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            step_q <= 2'd0;
        end else if (step_q != 2'd3) begin
            step_q <= step_q + 2'd1;
        end
    end

    assign seq_step_o = step_q;

    // Last step, first instruction word now on the bus
    assign seq_done_o = (step_q == 2'd3);

endmodule

`default_nettype wire
